// File: Makefile
SOURCES = $(shell grep -v '^+' filelist.f)

obj_dir/VmemSubsysTb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --top-module memSubsysTb -f filelist.f

run: obj_dir/VmemSubsysTb
	./obj_dir/VmemSubsysTb +verilator+error+limit+1000 | tee sim.log
	grep -q '^NO ERRORS$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: filelist.f
hdl/busPkg.sv
hdl/memMapPkg.sv
hdl/waitCounter.sv
hdl/sramSlave.sv
hdl/wbDecoder.sv
hdl/wbManager.sv
hdl/memSubsysTop.sv
test/memSubsys_assertions.sv
test/memSubsysTb.sv

// File: hdl/busPkg.sv
`default_nettype none

package busPkg;

    // byte address carried on every port
    localparam int ADDR_WIDTH = 32;

    // one full bus word, no byte selects
    localparam int DATA_WIDTH = 32;

    // bytes per word, used to turn byte addresses into word indices
    localparam int WORD_BYTES = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [DATA_WIDTH-1:0] dataT;

endpackage

`default_nettype wire

// File: hdl/memMapPkg.sv
`default_nettype none

package memMapPkg;

    // start of the on-chip SRAM region
    localparam busPkg::addrT SRAM_BASE = 32'h1000_0000;

    // largest SRAM the region can hold, in words
    localparam int SRAM_WORDS_MAX = 1024;

    // first byte address past the region
    localparam busPkg::addrT SRAM_LIMIT =
        SRAM_BASE + busPkg::addrT'(SRAM_WORDS_MAX * busPkg::WORD_BYTES);

    // everything outside [SRAM_BASE, SRAM_LIMIT) is unmapped

endpackage

`default_nettype wire

// File: hdl/memSubsysTop.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsysTop
    import busPkg::*;
#(
    parameter int WAIT_STATES = 2,
    parameter int DEPTH       = 64
) (
    input  logic clk,
    input  logic rst_i,
    input  logic req_i,
    input  logic we_i,
    input  addrT addr_i,
    input  dataT wdata_i,
    output logic ack_o,
    output logic err_o,
    output dataT rdata_o
);

    // manager to decoder, adr/we/data also fan out to the SRAM
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    addrT wbAdr;
    dataT wbDatW;

    // decoder back to manager
    logic wbAck;
    logic wbErr;
    dataT wbDatR;

    // decoder to SRAM
    logic sramStb;
    logic sramAck;
    dataT sramDat;

    wbManager wbManager_i (
        .clk    (clk),
        .rst_i  (rst_i),
        .req_i  (req_i),
        .we_i   (we_i),
        .addr_i (addr_i),
        .wdata_i(wdata_i),
        .ack_o  (ack_o),
        .err_o  (err_o),
        .rdata_o(rdata_o),
        .wbCyc_o(wbCyc),
        .wbStb_o(wbStb),
        .wbWe_o (wbWe),
        .wbAdr_o(wbAdr),
        .wbDat_o(wbDatW),
        .wbDat_i(wbDatR),
        .wbAck_i(wbAck),
        .wbErr_i(wbErr)
    );

    wbDecoder wbDecoder_i (
        .wbCyc_i  (wbCyc),
        .wbStb_i  (wbStb),
        .wbAdr_i  (wbAdr),
        .wbAck_o  (wbAck),
        .wbErr_o  (wbErr),
        .wbDat_o  (wbDatR),
        .sramStb_o(sramStb),
        .sramAck_i(sramAck),
        .sramDat_i(sramDat)
    );

    sramSlave #(
        .WAIT_STATES(WAIT_STATES),
        .DEPTH      (DEPTH)
    ) sramSlave_i (
        .clk  (clk),
        .rst_i(rst_i),
        .stb_i(sramStb),
        .we_i (wbWe),
        .adr_i(wbAdr),
        .dat_i(wbDatW),
        .ack_o(sramAck),
        .dat_o(sramDat)
    );

endmodule

`default_nettype wire

// File: hdl/sramSlave.sv
`timescale 1ns/1ps
`default_nettype none

module sramSlave
    import busPkg::*;
    import memMapPkg::*;
#(
    parameter int WAIT_STATES = 2,
    parameter int DEPTH       = 64
) (
    input  logic clk,
    input  logic rst_i,
    input  logic stb_i,
    input  logic we_i,
    input  addrT adr_i,
    input  dataT dat_i,
    output logic ack_o,
    output dataT dat_o
);

    localparam int IW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dataT          mem [DEPTH];
    addrT          wordAddr;
    logic [IW-1:0] index;
    logic          hit;

    // word offset into the region, folded onto the built depth
    assign wordAddr = (adr_i - SRAM_BASE) >> $clog2(WORD_BYTES);
    assign index    = IW'(wordAddr % DEPTH);

    waitCounter #(
        .WAIT_STATES(WAIT_STATES)
    ) waitCounter_i (
        .clk   (clk),
        .rst_i (rst_i),
        .run_i (stb_i),
        .done_o(hit)
    );

    // one ack per strobe, the counter only fires again after stb drops
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (we_i) begin
                mem[index] <= dat_i;
            end else begin
                dat_o <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/waitCounter.sv
`timescale 1ns/1ps
`default_nettype none

module waitCounter #(
    parameter int WAIT_STATES = 2
) (
    input  logic clk,
    input  logic rst_i,
    input  logic run_i,
    output logic done_o
);

    // one count past WAIT_STATES so the counter can park after done
    localparam int CW = $clog2(WAIT_STATES + 2);
    localparam logic [CW-1:0] LAST = CW'(WAIT_STATES);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (rst_i || !run_i) begin
            count <= '0;
        end else if (count <= LAST) begin
            count <= count + 1'b1;
        end
    end

    // high for a single cycle per run
    assign done_o = run_i && (count == LAST);

endmodule

`default_nettype wire

// File: hdl/wbDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module wbDecoder
    import busPkg::*;
    import memMapPkg::*;
(
    // from the manager
    input  logic wbCyc_i,
    input  logic wbStb_i,
    input  addrT wbAdr_i,

    // back to the manager
    output logic wbAck_o,
    output logic wbErr_o,
    output dataT wbDat_o,

    // SRAM slave
    output logic sramStb_o,
    input  logic sramAck_i,
    input  dataT sramDat_i
);

    logic access;
    logic sramHit;

    assign access  = wbCyc_i && wbStb_i;
    assign sramHit = (wbAdr_i >= SRAM_BASE) && (wbAdr_i < SRAM_LIMIT);

    // strobe only reaches the SRAM for mapped addresses
    assign sramStb_o = access && sramHit;

    // unmapped gets an immediate error, no slave is involved
    assign wbErr_o = access && !sramHit;

    // only one slave, so return path is just the SRAM
    assign wbAck_o = sramAck_i;
    assign wbDat_o = sramDat_i;

endmodule

`default_nettype wire

// File: hdl/wbManager.sv
`timescale 1ns/1ps
`default_nettype none

module wbManager
    import busPkg::*;
(
    input  logic clk,
    input  logic rst_i,

    // requester side, four-phase req/ack
    input  logic req_i,
    input  logic we_i,
    input  addrT addr_i,
    input  dataT wdata_i,
    output logic ack_o,
    output logic err_o,
    output dataT rdata_o,

    // bus side
    output logic wbCyc_o,
    output logic wbStb_o,
    output logic wbWe_o,
    output addrT wbAdr_o,
    output dataT wbDat_o,
    input  dataT wbDat_i,
    input  logic wbAck_i,
    input  logic wbErr_i
);

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        RESPOND
    } stateT;

    stateT state;
    logic  reqTaken;
    logic  busDone;

    assign reqTaken = (state == IDLE) && req_i;
    // a response only counts once the cycle is actually on the bus
    assign busDone  = (state == BUS) && wbCyc_o && (wbAck_i || wbErr_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= IDLE;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            wbCyc_o <= 1'b0;
            wbStb_o <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_i) begin
                        state <= BUS;
                    end
                end
                BUS: begin
                    if (!wbCyc_o) begin
                        // open the cycle one edge after capture
                        wbCyc_o <= 1'b1;
                        wbStb_o <= 1'b1;
                    end else if (busDone) begin
                        wbCyc_o <= 1'b0;
                        wbStb_o <= 1'b0;
                        ack_o   <= 1'b1;
                        err_o   <= wbErr_i;
                        state   <= RESPOND;
                    end
                end
                RESPOND: begin
                    // hold the response as long as the requester keeps req high
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        err_o <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (reqTaken) begin
            wbWe_o  <= we_i;
            wbAdr_o <= addr_i;
            wbDat_o <= wdata_i;
        end
        if (busDone) begin
            rdata_o <= wbErr_i ? '0 : wbDat_i;
        end
    end

endmodule

`default_nettype wire

// File: test/memSubsysTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsysTb
    import busPkg::*;
    import memMapPkg::*;
();

    localparam int WAIT_STATES = 2;
    localparam int DEPTH       = 64;
    localparam int PAIRS       = 16;
    // 54 transfers in the sequence, rounded up
    localparam int TRANSFERS   = 60;
    localparam int MAX_CYCLES  = 40 * TRANSFERS;
    // first byte past the SRAM region, four bytes per word
    localparam addrT SRAM_END  = SRAM_BASE + addrT'(4 * SRAM_WORDS_MAX);

    logic clk;
    logic rst;
    logic req;
    logic we;
    addrT addr;
    dataT wdata;
    logic ack;
    logic err;
    dataT rdata;

    logic [31:0] lfsrState;
    dataT model [DEPTH];
    addrT usedAddr [PAIRS];
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int testErrors = 0;
    int testCount = 0;

    memSubsysTop #(
        .WAIT_STATES(WAIT_STATES),
        .DEPTH      (DEPTH)
    ) dut_i (
        .clk    (clk),
        .rst_i  (rst),
        .req_i  (req),
        .we_i   (we),
        .addr_i (addr),
        .wdata_i(wdata),
        .ack_o  (ack),
        .err_o  (err),
        .rdata_o(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no finish after %0d cycles, a handshake hung", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic addrT sramAddr(input logic [31:0] word);
        return SRAM_BASE + addrT'(word * 4);
    endfunction

    // the built SRAM repeats every DEPTH words across the region
    function automatic int modelIndex(input addrT a);
        return int'(((a - SRAM_BASE) >> 2) % DEPTH);
    endfunction

    function automatic int totalErrors();
        return errors + dut_i.memSubsysAssert_i.fails;
    endfunction

    task automatic checkValue(input string name, input dataT expected, input dataT actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // one full four-phase handshake, req held for extra cycles when asked
    task automatic transfer(input logic wr, input addrT a, input dataT d, input int hold,
                            output dataT dataOut, output logic errOut);
        @(posedge clk);
        req   <= 1'b1;
        we    <= wr;
        addr  <= a;
        wdata <= d;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        dataOut = rdata;
        errOut  = err;
        repeat (hold) begin
            @(negedge clk);
            checkValue("ack_o", 32'd1, dataT'(ack));
            checkValue("rdata_o", dataOut, rdata);
        end
        @(posedge clk);
        req <= 1'b0;
        // ack_o falls at the edge that samples req_i low
        @(negedge clk);
        checkValue("ack_o", 32'd1, dataT'(ack));
        @(negedge clk);
        checkValue("ack_o", 32'd0, dataT'(ack));
    endtask

    task automatic writeMapped(input addrT a, input dataT d);
        dataT unusedData;
        logic errSeen;
        transfer(1'b1, a, d, 0, unusedData, errSeen);
        checkValue("err_o", 32'd0, dataT'(errSeen));
        model[modelIndex(a)] = d;
    endtask

    task automatic readMapped(input addrT a, input int hold);
        dataT got;
        logic errSeen;
        transfer(1'b0, a, '0, hold, got, errSeen);
        checkValue("err_o", 32'd0, dataT'(errSeen));
        checkValue("rdata_o", model[modelIndex(a)], got);
    endtask

    task automatic accessUnmapped(input logic wr, input addrT a);
        dataT unusedData;
        logic errSeen;
        transfer(wr, a, randomBits(32), 0, unusedData, errSeen);
        checkValue("err_o", 32'd1, dataT'(errSeen));
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, totalErrors() - testErrors);
        testErrors = totalErrors();
    endtask

    initial begin
        logic [31:0] word;
        rst   <= 1'b1;
        req   <= 1'b0;
        we    <= 1'b0;
        addr  <= '0;
        wdata <= '0;
        lfsrState = 32'h65e7;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        repeat (3) begin
            @(negedge clk);
            checkValue("ack_o", 32'd0, dataT'(ack));
            checkValue("err_o", 32'd0, dataT'(err));
        end
        endTest("idle after reset");

        for (int i = 0; i < PAIRS; i++) begin
            usedAddr[i] = sramAddr(randomBits($clog2(SRAM_WORDS_MAX)));
            writeMapped(usedAddr[i], randomBits(32));
        end
        for (int i = 0; i < PAIRS; i++) begin
            readMapped(usedAddr[i], 0);
        end
        endTest("random write then read");

        word = randomBits($clog2(SRAM_WORDS_MAX));
        writeMapped(sramAddr(word), randomBits(32));
        writeMapped(sramAddr(word), randomBits(32));
        readMapped(sramAddr(word), 0);
        endTest("double write");

        // edges of the region, and an alias that would fold onto usedAddr[0]
        accessUnmapped(1'b1, SRAM_BASE - 4);
        accessUnmapped(1'b1, SRAM_END + (usedAddr[0] - SRAM_BASE));
        accessUnmapped(1'b0, SRAM_END);
        readMapped(usedAddr[0], 0);
        readMapped(usedAddr[PAIRS-1], 0);
        endTest("unmapped access");

        writeMapped(usedAddr[1], randomBits(32));
        readMapped(usedAddr[1], 6);
        endTest("held request");

        for (int i = 0; i < 12; i++) begin
            if (randomBits(1) != 0) begin
                accessUnmapped(1'b0, 32'h8000_0000 | randomBits(31));
            end else begin
                readMapped(usedAddr[i % PAIRS], 0);
            end
        end
        endTest("mixed latency");

        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checks, totalErrors());
        if (totalErrors() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/memSubsys_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsys_assertions #(
    parameter int WAIT_STATES = 2
) (
    input logic clk,
    input logic rst_i,
    input logic req_i,
    input logic ack_i,
    input logic err_i,
    input logic cyc_i,
    input logic stb_i
);

    // failed assertions, read by the testbench for its summary
    int fails = 0;

    ackNeedsReq: assert property (@(posedge clk) disable iff (rst_i) $rose(ack_i) |-> req_i)
        else begin
            $error("ack_o rose while req_i was low");
            fails++;
        end

    errNeedsAck: assert property (@(posedge clk) disable iff (rst_i) err_i |-> ack_i)
        else begin
            $error("err_o high without ack_o");
            fails++;
        end

    stbInCyc: assert property (@(posedge clk) disable iff (rst_i) stb_i |-> cyc_i)
        else begin
            $error("bus strobe outside a bus cycle");
            fails++;
        end

    ackHeld: assert property (@(posedge clk) disable iff (rst_i) ack_i && req_i |=> ack_i)
        else begin
            $error("ack_o dropped while req_i was still high");
            fails++;
        end

    // req sampled high first at edge N, ack_o set at N+3+WAIT_STATES
    mappedLatency: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) && !err_i |-> $past(req_i, WAIT_STATES + 4) && !$past(req_i, WAIT_STATES + 5))
        else begin
            $error("mapped access did not complete in WAIT_STATES+3 cycles");
            fails++;
        end

    // unmapped: error answered at once, ack_o set at N+2
    unmappedLatency: assert property (@(posedge clk) disable iff (rst_i)
        $rose(ack_i) && err_i |-> $past(req_i, 3) && !$past(req_i, 4))
        else begin
            $error("unmapped access did not complete in 2 cycles");
            fails++;
        end

endmodule

bind memSubsysTop memSubsys_assertions #(
    .WAIT_STATES(WAIT_STATES)
) memSubsysAssert_i (
    .clk  (clk),
    .rst_i(rst_i),
    .req_i(req_i),
    .ack_i(ack_o),
    .err_i(err_o),
    .cyc_i(wbCyc),
    .stb_i(wbStb)
);

`default_nettype wire
